// ==== Makefile ====
# Verilator flow for the DIFI inserter testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module difi_inserter_tb \
		-Mdir $(OBJ_DIR) -o difi_inserter_tb

# Pass or fail comes from the log
run: compile
	./$(OBJ_DIR)/difi_inserter_tb | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/chdr_pkg.sv ====
// --------------------
// CHDR definitions
// Header layout, packet types and the context and payload beat formats
// of the user-side streams
// --------------------

package chdr_pkg;

  // Default CHDR bus width in bits
  localparam int CHDR_W = 64;

  // --------------------
  // Packet types
  // --------------------
  typedef enum logic [2:0] {
    CHDR_PKT_MGMT    = 3'd0,
    CHDR_PKT_STRS    = 3'd1,
    CHDR_PKT_STRC    = 3'd2,
    CHDR_PKT_RSVD_3  = 3'd3,
    CHDR_PKT_CTRL    = 3'd4,
    CHDR_PKT_RSVD_5  = 3'd5,
    CHDR_PKT_DATA    = 3'd6,
    CHDR_PKT_DATA_TS = 3'd7
  } chdr_pkt_type_e;

  // Header word, most significant field first
  typedef struct packed {
    logic [5:0]     vc;
    logic           eob;
    logic           eov;
    chdr_pkt_type_e pkt_type;
    logic [4:0]     num_mdata;
    logic [15:0]    seq_num;
    logic [15:0]    length;
    logic [15:0]    dst_epid;
  } chdr_header_t;

  // --------------------
  // Stream beats
  // --------------------
  typedef struct packed {
    logic [63:0] tdata;
    logic [3:0]  tuser;
    logic        tlast;
  } ctx_beat_t;

  // One 32-bit item per payload beat
  typedef struct packed {
    logic [31:0] tdata;
    logic        tkeep;
    logic        tlast;
  } pyld_beat_t;

endpackage

// ==== common/difi_pkg.sv ====
// --------------------
// DIFI definitions
// Inserter state encoding, fixed header constants, the decoded field
// set and the header word byte order
// --------------------

package difi_pkg;

  // --------------------
  // Inserter states
  // --------------------
  typedef enum logic [3:0] {
    ST_CTX_HDR,
    ST_CTX_TS,
    ST_CTX_PASS,
    ST_HDR_WORD,
    ST_STREAM_ID,
    ST_OUI,
    ST_CLASS_CODE,
    ST_INT_TS,
    ST_FRAC_TS_MS,
    ST_FRAC_TS_LS,
    ST_PYLD_PASS
  } difi_state_e;

  // Fields taken from the CHDR header for DIFI word 0
  typedef struct packed {
    logic [3:0]  seq_count;
    logic [15:0] pkt_size;
  } difi_fields_t;

  // --------------------
  // Header constants
  // --------------------

  // Seven DIFI header words added to the CHDR length
  localparam logic [15:0] DIFI_LEN_INCREASE = 16'd28;

  // DIFI header bytes counted in the packet size
  localparam logic [15:0] DIFI_HDR_OVERHEAD = 16'd20;

  localparam logic [1:0] DIFI_TSI = 2'b01;
  localparam logic [7:0] DIFI_PKT_TYPE = 8'b0001_1000;
  localparam logic [1:0] DIFI_TSF = 2'b10;

  // No time source yet, so both timestamps are fixed
  localparam logic [31:0] INT_TIMESTAMP = 32'h6666_6666;
  localparam logic [63:0] FRAC_TIMESTAMP = 64'hf0f0_f0f0_0f0f_0f0f;

  // Swap the two bytes inside each 16-bit half
  function automatic logic [31:0] swap_halves(input logic [31:0] word);
    logic [31:0] swapped;
    swapped = {word[23:16], word[31:24], word[7:0], word[15:8]};
    return swapped;
  endfunction

endpackage

// ==== difi_inserter/chdr_header_decode.sv ====
// --------------------
// CHDR header decode
// Raises the CHDR length for the inserted DIFI words and derives the
// DIFI packet size and sequence count
// --------------------

module chdr_header_decode (
  input  chdr_pkg::chdr_header_t in_ctx_data,
  output chdr_pkg::chdr_header_t updated_header,
  output difi_pkg::difi_fields_t fields,
  output logic                   has_time
);

  logic [15:0] ts_bytes;
  logic [15:0] mdata_bytes;
  logic [15:0] difi_bytes;

  // --------------------
  // Header rewrite
  // --------------------

  // Only the length changes
  always_comb begin
    updated_header        = in_ctx_data;
    updated_header.length = in_ctx_data.length + difi_pkg::DIFI_LEN_INCREASE;
  end

  // --------------------
  // DIFI size
  // --------------------

  assign has_time = (in_ctx_data.pkt_type == chdr_pkg::CHDR_PKT_DATA_TS);

  // Timestamp word and metadata words are 8 bytes each
  assign ts_bytes    = has_time ? 16'd8 : 16'd0;
  assign mdata_bytes = {8'd0, in_ctx_data.num_mdata, 3'b000};

  // Bytes that end up in the DIFI packet
  assign difi_bytes = in_ctx_data.length - ts_bytes - mdata_bytes
                    + difi_pkg::DIFI_HDR_OVERHEAD;

  // Size counts 32-bit words
  assign fields.pkt_size = {2'b00, difi_bytes[15:2]};

  // DIFI only carries a 4-bit sequence count
  assign fields.seq_count = in_ctx_data.seq_num[3:0];

endmodule

// ==== difi_inserter/difi_sequencer.sv ====
// --------------------
// DIFI sequencer
// Packet state machine: context beats, the seven DIFI header words,
// then the payload, with the decoded fields held for the header
// --------------------

module difi_sequencer (
  input  logic                   axis_data_clk,
  input  logic                   axis_data_rst,
  input  logic                   in_ctx_valid,
  input  logic                   in_ctx_last,
  input  logic                   out_ctx_ready,
  input  logic                   in_pyld_valid,
  input  logic                   in_pyld_last,
  input  logic                   out_pyld_ready,
  input  logic                   has_time,
  input  difi_pkg::difi_fields_t fields,
  output difi_pkg::difi_state_e  state,
  output difi_pkg::difi_fields_t latched_fields
);

  difi_pkg::difi_state_e state_next;
  logic                  ctx_xfer;
  logic                  pyld_xfer;

  // Context passes straight through, so the transfer is input valid
  // with output ready
  assign ctx_xfer  = in_ctx_valid && out_ctx_ready;
  assign pyld_xfer = in_pyld_valid && out_pyld_ready;

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      difi_pkg::ST_CTX_HDR: begin
        if (ctx_xfer) begin
          if (in_ctx_last) begin
            state_next = difi_pkg::ST_HDR_WORD;
          end else if (has_time) begin
            state_next = difi_pkg::ST_CTX_TS;
          end else begin
            state_next = difi_pkg::ST_CTX_PASS;
          end
        end
      end
      difi_pkg::ST_CTX_TS: begin
        if (ctx_xfer) begin
          state_next = in_ctx_last ? difi_pkg::ST_HDR_WORD : difi_pkg::ST_CTX_PASS;
        end
      end
      difi_pkg::ST_CTX_PASS: begin
        if (ctx_xfer && in_ctx_last) begin
          state_next = difi_pkg::ST_HDR_WORD;
        end
      end
      // Header words are always valid, so ready alone advances them
      difi_pkg::ST_HDR_WORD:    if (out_pyld_ready) state_next = difi_pkg::ST_STREAM_ID;
      difi_pkg::ST_STREAM_ID:   if (out_pyld_ready) state_next = difi_pkg::ST_OUI;
      difi_pkg::ST_OUI:         if (out_pyld_ready) state_next = difi_pkg::ST_CLASS_CODE;
      difi_pkg::ST_CLASS_CODE:  if (out_pyld_ready) state_next = difi_pkg::ST_INT_TS;
      difi_pkg::ST_INT_TS:      if (out_pyld_ready) state_next = difi_pkg::ST_FRAC_TS_MS;
      difi_pkg::ST_FRAC_TS_MS:  if (out_pyld_ready) state_next = difi_pkg::ST_FRAC_TS_LS;
      difi_pkg::ST_FRAC_TS_LS:  if (out_pyld_ready) state_next = difi_pkg::ST_PYLD_PASS;
      difi_pkg::ST_PYLD_PASS: begin
        if (pyld_xfer && in_pyld_last) begin
          state_next = difi_pkg::ST_CTX_HDR;
        end
      end
      default: begin
        state_next = difi_pkg::ST_CTX_HDR;
      end
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      state <= difi_pkg::ST_CTX_HDR;
    end else begin
      state <= state_next;
    end
  end

  // Capture size and sequence from the header beat
  always_ff @(posedge axis_data_clk) begin
    if (state == difi_pkg::ST_CTX_HDR && ctx_xfer) begin
      latched_fields <= fields;
    end
  end

endmodule

// ==== difi_inserter/difi_word_mux.sv ====
// --------------------
// DIFI word mux
// Steers context beats, the DIFI header words and the payload onto
// the output streams according to the sequencer state
// --------------------

module difi_word_mux #(
  parameter logic [31:0] STREAM_ID = 32'h8888_8888,
  parameter logic [23:0] OUI       = 24'h12_3456,
  parameter logic [15:0] ICC       = 16'hdead,
  parameter logic [15:0] PCC       = 16'hbeef
) (
  input  difi_pkg::difi_state_e  state,
  input  difi_pkg::difi_fields_t latched_fields,
  input  chdr_pkg::chdr_header_t updated_header,
  input  chdr_pkg::ctx_beat_t    in_ctx,
  input  logic                   in_ctx_valid,
  input  logic                   out_ctx_ready,
  input  chdr_pkg::pyld_beat_t   in_pyld,
  input  logic                   in_pyld_valid,
  input  logic                   out_pyld_ready,
  output chdr_pkg::ctx_beat_t    out_ctx,
  output logic                   out_ctx_valid,
  output logic                   in_ctx_ready,
  output chdr_pkg::pyld_beat_t   out_pyld,
  output logic                   out_pyld_valid,
  output logic                   in_pyld_ready
);

  logic [31:0] hdr_word;
  logic        ctx_phase;

  assign ctx_phase = (state == difi_pkg::ST_CTX_HDR) || (state == difi_pkg::ST_CTX_TS)
                  || (state == difi_pkg::ST_CTX_PASS);

  // --------------------
  // Context stream
  // --------------------
  always_comb begin
    out_ctx = in_ctx;
    if (state == difi_pkg::ST_CTX_HDR) begin
      out_ctx.tdata = updated_header;
    end
  end

  assign out_ctx_valid = ctx_phase && in_ctx_valid;
  assign in_ctx_ready  = ctx_phase && out_ctx_ready;

  // --------------------
  // Header words
  // --------------------
  always_comb begin
    case (state)
      difi_pkg::ST_HDR_WORD: begin
        hdr_word = {difi_pkg::DIFI_PKT_TYPE, difi_pkg::DIFI_TSI, difi_pkg::DIFI_TSF,
                    latched_fields.seq_count, latched_fields.pkt_size};
      end
      difi_pkg::ST_STREAM_ID:  hdr_word = STREAM_ID;
      difi_pkg::ST_OUI:        hdr_word = {8'h00, OUI};
      difi_pkg::ST_CLASS_CODE: hdr_word = {ICC, PCC};
      difi_pkg::ST_INT_TS:     hdr_word = difi_pkg::INT_TIMESTAMP;
      difi_pkg::ST_FRAC_TS_MS: hdr_word = difi_pkg::FRAC_TIMESTAMP[63:32];
      difi_pkg::ST_FRAC_TS_LS: hdr_word = difi_pkg::FRAC_TIMESTAMP[31:0];
      default:                 hdr_word = '0;
    endcase
  end

  // --------------------
  // Payload stream
  // --------------------
  always_comb begin
    if (state == difi_pkg::ST_PYLD_PASS) begin
      out_pyld       = in_pyld;
      out_pyld_valid = in_pyld_valid;
      in_pyld_ready  = out_pyld_ready;
    end else if (ctx_phase) begin
      // Payload held off until the context has gone out
      out_pyld       = '0;
      out_pyld_valid = 1'b0;
      in_pyld_ready  = 1'b0;
    end else begin
      out_pyld.tdata = difi_pkg::swap_halves(hdr_word);
      out_pyld.tkeep = 1'b1;
      out_pyld.tlast = 1'b0;
      out_pyld_valid = 1'b1;
      in_pyld_ready  = 1'b0;
    end
  end

endmodule

// ==== sim.f ====
common/chdr_pkg.sv
common/difi_pkg.sv
difi_inserter/chdr_header_decode.sv
difi_inserter/difi_sequencer.sv
difi_inserter/difi_word_mux.sv
src/difi_inserter_top.sv
tb/difi_inserter_tb.sv

// ==== src/difi_inserter_top.sv ====
// --------------------
// DIFI inserter top level
// Turns a CHDR context and payload pair into a DIFI data packet
// --------------------

module difi_inserter_top #(
  parameter int          CHDR_W    = chdr_pkg::CHDR_W,
  parameter logic [31:0] STREAM_ID = 32'h8888_8888,
  parameter logic [23:0] OUI       = 24'h12_3456,
  parameter logic [15:0] ICC       = 16'hdead,
  parameter logic [15:0] PCC       = 16'hbeef
) (
  input  logic                 axis_data_clk,
  input  logic                 axis_data_rst,
  // Context in and out
  input  chdr_pkg::ctx_beat_t  in_ctx,
  input  logic                 in_ctx_valid,
  output logic                 in_ctx_ready,
  output chdr_pkg::ctx_beat_t  out_ctx,
  output logic                 out_ctx_valid,
  input  logic                 out_ctx_ready,
  // Payload in and out
  input  chdr_pkg::pyld_beat_t in_pyld,
  input  logic                 in_pyld_valid,
  output logic                 in_pyld_ready,
  output chdr_pkg::pyld_beat_t out_pyld,
  output logic                 out_pyld_valid,
  input  logic                 out_pyld_ready
);

  logic [CHDR_W-1:0]      ctx_tdata;
  chdr_pkg::chdr_header_t updated_header;
  difi_pkg::difi_fields_t dec_fields;
  difi_pkg::difi_fields_t latched_fields;
  difi_pkg::difi_state_e  state;
  logic                   has_time;

  // Header sits in the low 64 bits of the context beat
  assign ctx_tdata = in_ctx.tdata;

  chdr_header_decode u_decode (
    .in_ctx_data    (ctx_tdata[63:0]),
    .updated_header (updated_header),
    .fields         (dec_fields),
    .has_time       (has_time)
  );

  difi_sequencer u_sequencer (
    .axis_data_clk  (axis_data_clk),
    .axis_data_rst  (axis_data_rst),
    .in_ctx_valid   (in_ctx_valid),
    .in_ctx_last    (in_ctx.tlast),
    .out_ctx_ready  (out_ctx_ready),
    .in_pyld_valid  (in_pyld_valid),
    .in_pyld_last   (in_pyld.tlast),
    .out_pyld_ready (out_pyld_ready),
    .has_time       (has_time),
    .fields         (dec_fields),
    .state          (state),
    .latched_fields (latched_fields)
  );

  difi_word_mux #(
    .STREAM_ID (STREAM_ID),
    .OUI       (OUI),
    .ICC       (ICC),
    .PCC       (PCC)
  ) u_word_mux (
    .state          (state),
    .latched_fields (latched_fields),
    .updated_header (updated_header),
    .in_ctx         (in_ctx),
    .in_ctx_valid   (in_ctx_valid),
    .out_ctx_ready  (out_ctx_ready),
    .in_pyld        (in_pyld),
    .in_pyld_valid  (in_pyld_valid),
    .out_pyld_ready (out_pyld_ready),
    .out_ctx        (out_ctx),
    .out_ctx_valid  (out_ctx_valid),
    .in_ctx_ready   (in_ctx_ready),
    .out_pyld       (out_pyld),
    .out_pyld_valid (out_pyld_valid),
    .in_pyld_ready  (in_pyld_ready)
  );

endmodule

// ==== tb/difi_inserter_tb.sv ====
// --------------------
// DIFI inserter testbench
// Random CHDR packets against a queue model of the expected context
// and DIFI payload streams, with random back-pressure
// --------------------

module difi_inserter_tb;

  localparam int NUM_PKTS = 40;
  // Watchdog limit in clock cycles
  localparam int MAX_CYCLES = NUM_PKTS * 200;

  logic                 axis_data_clk;
  logic                 axis_data_rst;
  chdr_pkg::ctx_beat_t  in_ctx;
  logic                 in_ctx_valid;
  logic                 in_ctx_ready;
  chdr_pkg::ctx_beat_t  out_ctx;
  logic                 out_ctx_valid;
  logic                 out_ctx_ready;
  chdr_pkg::pyld_beat_t in_pyld;
  logic                 in_pyld_valid;
  logic                 in_pyld_ready;
  chdr_pkg::pyld_beat_t out_pyld;
  logic                 out_pyld_valid;
  logic                 out_pyld_ready;

  integer               seed;
  int                   errors;
  logic                 running;
  logic                 ctx_fired;
  logic                 pyld_fired;
  logic                 pyld_phase;
  logic                 ctx_hold;
  logic                 pyld_hold;
  chdr_pkg::ctx_beat_t  held_ctx;
  chdr_pkg::ctx_beat_t  exp_ctx;
  chdr_pkg::pyld_beat_t held_pyld;
  chdr_pkg::pyld_beat_t exp_pyld;

  // Beats still to drive and beats still expected
  chdr_pkg::ctx_beat_t  ctx_in_q[$];
  chdr_pkg::ctx_beat_t  exp_ctx_q[$];
  chdr_pkg::pyld_beat_t pyld_in_q[$];
  chdr_pkg::pyld_beat_t exp_pyld_q[$];

  difi_inserter_top #(
    .CHDR_W    (64),
    .STREAM_ID (32'h8888_8888),
    .OUI       (24'h12_3456),
    .ICC       (16'hdead),
    .PCC       (16'hbeef)
  ) uut (
    .axis_data_clk  (axis_data_clk),
    .axis_data_rst  (axis_data_rst),
    .in_ctx         (in_ctx),
    .in_ctx_valid   (in_ctx_valid),
    .in_ctx_ready   (in_ctx_ready),
    .out_ctx        (out_ctx),
    .out_ctx_valid  (out_ctx_valid),
    .out_ctx_ready  (out_ctx_ready),
    .in_pyld        (in_pyld),
    .in_pyld_valid  (in_pyld_valid),
    .in_pyld_ready  (in_pyld_ready),
    .out_pyld       (out_pyld),
    .out_pyld_valid (out_pyld_valid),
    .out_pyld_ready (out_pyld_ready)
  );

  initial begin
    axis_data_clk = 1'b0;
    forever #5 axis_data_clk = ~axis_data_clk;
  end

  // --------------------
  // Reference model
  // --------------------

  // DIFI words go out with the bytes of each 16-bit half exchanged
  function automatic logic [31:0] swap_bytes16(input logic [31:0] w);
    return {w[23:16], w[31:24], w[7:0], w[15:8]};
  endfunction

  task automatic push_header_word(input logic [31:0] word);
    chdr_pkg::pyld_beat_t b;
    b.tdata = swap_bytes16(word);
    b.tkeep = 1'b1;
    b.tlast = 1'b0;
    exp_pyld_q.push_back(b);
  endtask

  task automatic build_packet();
    chdr_pkg::chdr_header_t hdr;
    chdr_pkg::chdr_header_t exp_hdr;
    chdr_pkg::ctx_beat_t    beat;
    chdr_pkg::pyld_beat_t   pbeat;
    logic [31:0]            r;
    logic [31:0]            r2;
    logic                   ts;
    logic [4:0]             nmd;
    logic [4:0]             nw;
    logic [15:0]            size;
    int                     extra;
    r = $random(seed);
    r2 = $random(seed);
    ts = r[0];
    nmd = {3'b000, r[2:1]};
    nw = {1'b0, r[6:3]} + 5'd1;
    extra = int'(ts) + int'(nmd);
    hdr.vc = r[12:7];
    hdr.eob = r[13];
    hdr.eov = r[14];
    hdr.pkt_type = ts ? chdr_pkg::CHDR_PKT_DATA_TS : chdr_pkg::CHDR_PKT_DATA;
    hdr.num_mdata = nmd;
    hdr.seq_num = r[31:16];
    // Header, optional timestamp, metadata and payload bytes
    hdr.length = 16'd8 + (ts ? 16'd8 : 16'd0) + {8'd0, nmd, 3'b000} + {9'd0, nw, 2'b00};
    hdr.dst_epid = r2[15:0];
    beat.tdata = hdr;
    beat.tuser = r2[19:16];
    beat.tlast = (extra == 0);
    ctx_in_q.push_back(beat);
    exp_hdr = hdr;
    exp_hdr.length = hdr.length + 16'd28;
    beat.tdata = exp_hdr;
    exp_ctx_q.push_back(beat);
    for (int i = 0; i < extra; i++) begin
      r = $random(seed);
      beat.tdata = {$random(seed), $random(seed)};
      beat.tuser = r[3:0];
      beat.tlast = (i == extra - 1);
      ctx_in_q.push_back(beat);
      exp_ctx_q.push_back(beat);
    end
    // Seven DIFI header words ahead of the payload words
    size = 16'd7 + {11'd0, nw};
    push_header_word({8'b0001_1000, 2'b01, 2'b10, hdr.seq_num[3:0], size});
    push_header_word(32'h8888_8888);
    push_header_word({8'h00, 24'h12_3456});
    push_header_word({16'hdead, 16'hbeef});
    push_header_word(32'h6666_6666);
    push_header_word(32'hf0f0_f0f0);
    push_header_word(32'h0f0f_0f0f);
    for (int i = 0; i < int'(nw); i++) begin
      r = $random(seed);
      r2 = $random(seed);
      pbeat.tdata = r;
      pbeat.tkeep = r2[0];
      pbeat.tlast = (i == int'(nw) - 1);
      pyld_in_q.push_back(pbeat);
      exp_pyld_q.push_back(pbeat);
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_inputs();
    logic [31:0] r;
    forever begin
      @(negedge axis_data_clk);
      r = $random(seed);
      out_pyld_ready = r[0];
      out_ctx_ready = (r[2:1] != 2'b00);
      if (ctx_fired) void'(ctx_in_q.pop_front());
      if (pyld_fired) void'(pyld_in_q.pop_front());
      // An offered beat stays until it is taken
      if (!(in_ctx_valid && !ctx_fired)) begin
        in_ctx_valid = (ctx_in_q.size() > 0) && (r[5:3] != 3'b000);
        if (in_ctx_valid) in_ctx = ctx_in_q[0];
      end
      if (!(in_pyld_valid && !pyld_fired)) begin
        in_pyld_valid = (pyld_in_q.size() > 0) && (r[8:6] != 3'b000);
        if (in_pyld_valid) in_pyld = pyld_in_q[0];
      end
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic compare_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // Payload side quiet outside the header and payload phase
  assert property (@(posedge axis_data_clk) disable iff (axis_data_rst || !running)
    !pyld_phase |-> !out_pyld_valid) else begin
    errors++;
    $display("CHECK FAILED at %0t: out_pyld_valid expected 0 actual %0b",
             $time, $sampled(out_pyld_valid));
  end

  assert property (@(posedge axis_data_clk) disable iff (axis_data_rst || !running)
    !pyld_phase |-> !in_pyld_ready) else begin
    errors++;
    $display("CHECK FAILED at %0t: in_pyld_ready expected 0 actual %0b",
             $time, $sampled(in_pyld_ready));
  end

  // No context accepted until the payload tlast is out
  assert property (@(posedge axis_data_clk) disable iff (axis_data_rst || !running)
    pyld_phase |-> !in_ctx_ready) else begin
    errors++;
    $display("CHECK FAILED at %0t: in_ctx_ready expected 0 actual %0b",
             $time, $sampled(in_ctx_ready));
  end

  assert property (@(posedge axis_data_clk) disable iff (axis_data_rst || !running)
    pyld_phase |-> !out_ctx_valid) else begin
    errors++;
    $display("CHECK FAILED at %0t: out_ctx_valid expected 0 actual %0b",
             $time, $sampled(out_ctx_valid));
  end

  always @(posedge axis_data_clk) begin
    if (running) begin
      ctx_fired = in_ctx_valid && in_ctx_ready;
      pyld_fired = in_pyld_valid && in_pyld_ready;
      // Stalled beats must hold
      if (ctx_hold) begin
        compare_value("out_ctx_valid", 72'(1'b1), 72'(out_ctx_valid));
        compare_value("out_ctx", 72'(held_ctx), 72'(out_ctx));
      end
      if (pyld_hold) begin
        compare_value("out_pyld_valid", 72'(1'b1), 72'(out_pyld_valid));
        compare_value("out_pyld", 72'(held_pyld), 72'(out_pyld));
      end
      if (out_ctx_valid && out_ctx_ready) begin
        if (exp_ctx_q.size() == 0) begin
          errors++;
          $display("ERROR at %0t: a context beat came out when none was expected", $time);
        end else begin
          exp_ctx = exp_ctx_q.pop_front();
          compare_value("out_ctx.tdata", 72'(exp_ctx.tdata), 72'(out_ctx.tdata));
          compare_value("out_ctx.tuser", 72'(exp_ctx.tuser), 72'(out_ctx.tuser));
          compare_value("out_ctx.tlast", 72'(exp_ctx.tlast), 72'(out_ctx.tlast));
        end
        if (out_ctx.tlast) pyld_phase <= 1'b1;
      end
      if (out_pyld_valid && out_pyld_ready) begin
        if (exp_pyld_q.size() == 0) begin
          errors++;
          $display("ERROR at %0t: a payload word came out when none was expected", $time);
        end else begin
          exp_pyld = exp_pyld_q.pop_front();
          compare_value("out_pyld.tdata", 72'(exp_pyld.tdata), 72'(out_pyld.tdata));
          compare_value("out_pyld.tkeep", 72'(exp_pyld.tkeep), 72'(out_pyld.tkeep));
          compare_value("out_pyld.tlast", 72'(exp_pyld.tlast), 72'(out_pyld.tlast));
        end
        if (out_pyld.tlast) pyld_phase <= 1'b0;
      end
      ctx_hold = out_ctx_valid && !out_ctx_ready;
      held_ctx = out_ctx;
      pyld_hold = out_pyld_valid && !out_pyld_ready;
      held_pyld = out_pyld;
    end
  end

  // --------------------
  // Run control
  // --------------------
  initial begin
    seed = 63351;
    errors = 0;
    running = 1'b0;
    ctx_fired = 1'b0;
    pyld_fired = 1'b0;
    pyld_phase = 1'b0;
    ctx_hold = 1'b0;
    pyld_hold = 1'b0;
    axis_data_rst = 1'b1;
    in_ctx = '0;
    in_ctx_valid = 1'b0;
    out_ctx_ready = 1'b0;
    in_pyld = '0;
    in_pyld_valid = 1'b0;
    out_pyld_ready = 1'b0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      build_packet();
    end
    repeat (5) @(negedge axis_data_clk);
    axis_data_rst = 1'b0;
    running = 1'b1;
    fork
      drive_inputs();
    join_none
    while (exp_ctx_q.size() != 0 || exp_pyld_q.size() != 0) begin
      @(posedge axis_data_clk);
    end
    repeat (4) @(posedge axis_data_clk);
    if (ctx_in_q.size() != 0 || pyld_in_q.size() != 0) begin
      errors++;
      $display("ERROR: input beats were left over after all output was seen");
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge axis_data_clk);
    $display("ERROR: timeout after %0d cycles with %0d context and %0d payload beats pending",
             MAX_CYCLES, exp_ctx_q.size(), exp_pyld_q.size());
    $display("Run stopped with %0d errors", errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
